// ==== src/zx_bus_pkg.sv ====
// Shared types and constants for the Spectrum bus and paging core that every module imports
package zx_bus_pkg;

	// ========================================
	// Machine model and access kinds
	// ========================================

	// Machine model latched while reset is high
	typedef enum logic [1:0] {
		MODEL_48K   = 2'd0,
		MODEL_128K  = 2'd1,
		MODEL_PLUS3 = 2'd2
	} zx_model_t;

	// Kind of one bus cycle after address decode
	typedef enum logic [2:0] {
		ACC_MEM_RD       = 3'd0,
		ACC_MEM_WR       = 3'd1,
		ACC_PORT_7FFD_WR = 3'd2,
		ACC_PORT_1FFD_WR = 3'd3,
		ACC_ULA_WR       = 3'd4,
		ACC_ULA_RD       = 3'd5,
		ACC_IO_OTHER_WR  = 3'd6,
		ACC_IO_OTHER_RD  = 3'd7
	} zx_access_t;

	// ========================================
	// Widths
	// ========================================

	// Z80 address and data bus
	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W     = 8;

	// Offset inside one 16K slot
	localparam int SLOT_OFS_W = 14;

	// RAM page number (8 x 16K) and ROM bank number (4 x 16K)
	localparam int PAGE_W     = 3;
	localparam int ROM_BANK_W = 2;

	// ========================================
	// Fixed values
	// ========================================

	// Floating bus value for ports nobody answers
	localparam logic [DATA_W-1:0] PORT_IDLE_DATA = 8'hFF;

	// Slots 1 and 2 outside the +3 special modes
	localparam logic [PAGE_W-1:0] FIXED_PAGE_SLOT1 = 3'd5;
	localparam logic [PAGE_W-1:0] FIXED_PAGE_SLOT2 = 3'd2;

endpackage

// ==== src/zx_bus_decode.sv ====
// Bus front end that catches the rising of each Wishbone request and registers its decoded kind
module zx_bus_decode
	import zx_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	// Wishbone slave side
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic                  wb_io,
	input  logic [CPU_ADDR_W-1:0] wb_adr,
	input  logic [DATA_W-1:0]     wb_dat_w,

	// Latched machine model from the execute stage
	input  zx_model_t             model_q,

	// Decoded access with its one-cycle strobe
	output logic                  acc_valid,
	output zx_access_t            acc_kind,
	output logic [CPU_ADDR_W-1:0] acc_adr,
	output logic [DATA_W-1:0]     acc_dat
);

	logic       taken;
	logic       new_req;
	logic       sel_7ffd;
	logic       sel_1ffd;
	logic       sel_ula;
	zx_access_t kind_n;

	// Only the first edge of a request counts
	assign new_req = wb_cyc & wb_stb & ~taken;

	// Partial port decode as on the real machines
	assign sel_7ffd = ~wb_adr[15] & ~wb_adr[1] & (wb_adr[14] | (model_q != MODEL_PLUS3));
	assign sel_1ffd = (model_q == MODEL_PLUS3) & (wb_adr[15:12] == 4'b0001) & ~wb_adr[1];
	assign sel_ula  = ~wb_adr[0];

	always_comb begin
		if (!wb_io)
			kind_n = wb_we ? ACC_MEM_WR : ACC_MEM_RD;
		else if (wb_we) begin
			if (sel_7ffd)
				kind_n = ACC_PORT_7FFD_WR;
			else if (sel_1ffd)
				kind_n = ACC_PORT_1FFD_WR;
			else if (sel_ula)
				kind_n = ACC_ULA_WR;
			else
				kind_n = ACC_IO_OTHER_WR;
		end else
			kind_n = sel_ula ? ACC_ULA_RD : ACC_IO_OTHER_RD;
	end

	// Held until the master drops stb after its ack
	always_ff @(posedge clk_sys) begin
		if (reset)
			taken <= 1'b0;
		else if (!wb_stb)
			taken <= 1'b0;
		else if (new_req)
			taken <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			acc_valid <= 1'b0;
		else
			acc_valid <= new_req;
	end

	// Payload rides along with the strobe
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			acc_kind <= kind_n;
			acc_adr  <= wb_adr;
			acc_dat  <= wb_dat_w;
		end
	end

endmodule

// ==== src/zx_paging_exec.sv ====
// Paging and ULA register file that decoded port writes update one cycle after each access
module zx_paging_exec
	import zx_bus_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,

	// Model strap, taken while reset is high
	input  zx_model_t         model,

	// Decoded access from the front end
	input  logic              acc_valid,
	input  zx_access_t        acc_kind,
	input  logic [DATA_W-1:0] acc_dat,

	// Register state for the decoder and the result stage
	output zx_model_t         model_q,
	output logic [DATA_W-1:0] page_reg,
	output logic [DATA_W-1:0] page_reg_plus3,

	// ULA port outputs
	output logic [2:0]        border_color,
	output logic              ear_out,
	output logic              mic_out
);

	logic page_lock;
	logic wr_7ffd;
	logic wr_1ffd;
	logic wr_ula;

	// 48K has no paging, and 7FFD bit 5 freezes it until reset
	assign page_lock = page_reg[5] | (model_q == MODEL_48K);

	assign wr_7ffd = acc_valid & (acc_kind == ACC_PORT_7FFD_WR) & ~page_lock;
	assign wr_1ffd = acc_valid & (acc_kind == ACC_PORT_1FFD_WR) & ~page_lock
	                 & (model_q == MODEL_PLUS3);
	assign wr_ula  = acc_valid & (acc_kind == ACC_ULA_WR);

	// ========================================
	// Model latch
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model;
	end

	// ========================================
	// Paging ports
	// ========================================

	// 7FFD holds the slot 3 RAM page in bits 2-0, screen in bit 3, ROM in bit 4 and lock in bit 5
	always_ff @(posedge clk_sys) begin
		if (reset)
			page_reg <= '0;
		else if (wr_7ffd)
			page_reg <= acc_dat;
	end

	// 1FFD bit 0 selects special mode and bits 2-1 the config or ROM high bit
	always_ff @(posedge clk_sys) begin
		if (reset)
			page_reg_plus3 <= '0;
		else if (wr_1ffd)
			page_reg_plus3 <= acc_dat;
	end

	// ========================================
	// ULA port
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (wr_ula) begin
			border_color <= acc_dat[2:0];
			mic_out      <= acc_dat[3];
			ear_out      <= acc_dat[4];
		end
	end

endmodule

// ==== src/zx_bus_result.sv ====
// Result stage that maps memory cycles to physical pages, builds port read data and acknowledges
module zx_bus_result
	import zx_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  acc_valid,
	input  zx_access_t            acc_kind,
	input  logic [CPU_ADDR_W-1:0] acc_adr,

	input  logic [DATA_W-1:0]     page_reg,
	input  logic [DATA_W-1:0]     page_reg_plus3,
	input  zx_model_t             model_q,
	input  logic [4:0]            key_data,
	input  logic                  tape_in,

	output logic                  wb_ack,
	output logic [DATA_W-1:0]     wb_dat_r,
	output logic                  mem_rom,
	output logic [PAGE_W-1:0]     mem_page,
	output logic [SLOT_OFS_W-1:0] mem_ofs,
	output logic                  mem_we
);

	logic [1:0]            slot;
	logic [1:0]            cfg;
	logic [ROM_BANK_W-1:0] rom_bank;
	logic                  rom_n;
	logic [PAGE_W-1:0]     page_n;
	logic [DATA_W-1:0]     rd_n;

	assign slot = acc_adr[CPU_ADDR_W-1 -: 2];
	assign cfg  = page_reg_plus3[2:1];

	// ROM bank for slot 0
	always_comb begin
		case (model_q)
			MODEL_48K:   rom_bank = 2'd1;
			MODEL_PLUS3: rom_bank = {page_reg_plus3[2], page_reg[4]};
			default:     rom_bank = {1'b0, page_reg[4]};
		endcase
	end

	always_comb begin
		rom_n = 1'b0;
		if (page_reg_plus3[0]) begin
			// All-RAM modes set the top bit except in config 0 and put page 3 in slot 3 for
			// configs 2 and 3
			page_n = {(cfg != 2'd0), slot};
			if (cfg[1] && slot == 2'd3)
				page_n = 3'd3;
			if (cfg == 2'd3 && slot == 2'd1)
				page_n = 3'd7;
		end else begin
			case (slot)
				2'd0: begin
					rom_n  = 1'b1;
					page_n = {{(PAGE_W-ROM_BANK_W){1'b0}}, rom_bank};
				end
				2'd1:    page_n = FIXED_PAGE_SLOT1;
				2'd2:    page_n = FIXED_PAGE_SLOT2;
				default: page_n = page_reg[PAGE_W-1:0];
			endcase
		end
	end

	// ULA read returns the keyboard half-row and the inverted tape level
	assign rd_n = (acc_kind == ACC_ULA_RD) ? {1'b1, ~tape_in, 1'b1, key_data} : PORT_IDLE_DATA;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			wb_ack <= acc_valid;
			if (acc_valid)
				mem_we <= (acc_kind == ACC_MEM_WR) & ~rom_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (acc_valid) begin
			mem_rom  <= rom_n;
			mem_page <= page_n;
			mem_ofs  <= acc_adr[SLOT_OFS_W-1:0];
			wb_dat_r <= rd_n;
		end
	end

endmodule

// ==== src/zx_bus_top.sv ====
// Top of the CPU bus and paging core; the Wishbone slave faces the Z80 bridge, mem_* face RAM
module zx_bus_top
	import zx_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	// Wishbone classic slave
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic                  wb_io,
	input  logic [CPU_ADDR_W-1:0] wb_adr,
	input  logic [DATA_W-1:0]     wb_dat_w,
	output logic [DATA_W-1:0]     wb_dat_r,
	output logic                  wb_ack,

	// Board straps and inputs
	input  zx_model_t             model,
	input  logic [4:0]            key_data,
	input  logic                  tape_in,

	// Physical memory access
	output logic                  mem_rom,
	output logic [PAGE_W-1:0]     mem_page,
	output logic [SLOT_OFS_W-1:0] mem_ofs,
	output logic                  mem_we,

	// ULA port
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out
);

	logic                  acc_valid;
	zx_access_t            acc_kind;
	logic [CPU_ADDR_W-1:0] acc_adr;
	logic [DATA_W-1:0]     acc_dat;
	zx_model_t             model_q;
	logic [DATA_W-1:0]     page_reg;
	logic [DATA_W-1:0]     page_reg_plus3;

	zx_bus_decode i_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_io     (wb_io),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.model_q   (model_q),
		.acc_valid (acc_valid),
		.acc_kind  (acc_kind),
		.acc_adr   (acc_adr),
		.acc_dat   (acc_dat)
	);

	zx_paging_exec i_exec (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.model          (model),
		.acc_valid      (acc_valid),
		.acc_kind       (acc_kind),
		.acc_dat        (acc_dat),
		.model_q        (model_q),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.border_color   (border_color),
		.ear_out        (ear_out),
		.mic_out        (mic_out)
	);

	zx_bus_result i_result (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.acc_valid      (acc_valid),
		.acc_kind       (acc_kind),
		.acc_adr        (acc_adr),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.model_q        (model_q),
		.key_data       (key_data),
		.tape_in        (tape_in),
		.wb_ack         (wb_ack),
		.wb_dat_r       (wb_dat_r),
		.mem_rom        (mem_rom),
		.mem_page       (mem_page),
		.mem_ofs        (mem_ofs),
		.mem_we         (mem_we)
	);

endmodule

// ==== verif/zx_bus_chk.sv ====
// Assertion checker for the Wishbone handshake and reset state, bound into the bus top level
module zx_bus_chk (
	input logic clk_sys,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic mem_we
);

	// Acknowledge only inside an open request
	ack_in_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack high without cyc and stb");

	// One-cycle acknowledge
	ack_single: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	// Fixed latency of the core
	ack_latency: assert property (@(posedge clk_sys) disable iff (reset)
		(wb_cyc && $rose(wb_stb)) |-> ##2 wb_ack)
		else $error("wb_ack not 2 cycles after the request");

	ack_reset: assert property (@(posedge clk_sys)
		reset |=> (!wb_ack && !mem_we))
		else $error("wb_ack or mem_we high after a reset edge");

endmodule

bind zx_bus_top zx_bus_chk i_chk (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.mem_we  (mem_we)
);

// ==== verif/zx_bus_tb.sv ====
// Self-checking testbench for the bus core; run it as the simulation top with the file list
module zx_bus_tb
	import zx_bus_pkg::*;
();

	logic                  clk_sys;
	logic                  reset;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic                  wb_io;
	logic [CPU_ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0]     wb_dat_w;
	logic [DATA_W-1:0]     wb_dat_r;
	logic                  wb_ack;
	zx_model_t             model;
	logic [4:0]            key_data;
	logic                  tape_in;
	logic                  mem_rom;
	logic [PAGE_W-1:0]     mem_page;
	logic [SLOT_OFS_W-1:0] mem_ofs;
	logic                  mem_we;
	logic [2:0]            border_color;
	logic                  ear_out;
	logic                  mic_out;

	// Reference copies of the machine state
	zx_model_t             ref_model;
	logic [DATA_W-1:0]     ref_7ffd;
	logic [DATA_W-1:0]     ref_1ffd;
	logic [2:0]            ref_border;
	logic                  ref_ear;
	logic                  ref_mic;

	// Expected response of the access in flight
	zx_access_t            exp_kind;
	logic                  exp_rom;
	logic [PAGE_W-1:0]     exp_page;
	logic [SLOT_OFS_W-1:0] exp_ofs;
	logic                  exp_we;
	logic [DATA_W-1:0]     exp_dat;

	string test_name;
	int    seed = 32'h1951e24a;
	int    err_count;
	int    rnd;

	zx_bus_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic void zx_ref_access(input logic we, input logic io,
		input logic [CPU_ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
		input logic [4:0] keys, input logic tape);
		logic [1:0]  slot;
		logic [11:0] row;
		logic        locked;
		slot    = adr[15:14];
		locked  = ref_7ffd[5] || (ref_model == MODEL_48K);
		exp_ofs = adr[SLOT_OFS_W-1:0];
		exp_rom = 1'b0;
		exp_we  = 1'b0;
		exp_dat = PORT_IDLE_DATA;
		if (!io) begin
			exp_kind = we ? ACC_MEM_WR : ACC_MEM_RD;
			if (ref_1ffd[0]) begin
				// Special mode pages from slot 3 down to slot 0
				case (ref_1ffd[2:1])
					2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
					2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
					2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
					default: row = {3'd3, 3'd6, 3'd7, 3'd4};
				endcase
				exp_page = row[3*slot +: 3];
			end else if (slot == 2'd0) begin
				exp_rom = 1'b1;
				case (ref_model)
					MODEL_48K:   exp_page = 3'd1;
					MODEL_PLUS3: exp_page = {1'b0, ref_1ffd[2], ref_7ffd[4]};
					default:     exp_page = {2'b00, ref_7ffd[4]};
				endcase
			end else if (slot == 2'd1)
				exp_page = FIXED_PAGE_SLOT1;
			else if (slot == 2'd2)
				exp_page = FIXED_PAGE_SLOT2;
			else
				exp_page = ref_7ffd[2:0];
			exp_we = we && !exp_rom;
		end else if (we) begin
			if (!adr[15] && !adr[1] && (adr[14] || ref_model != MODEL_PLUS3)) begin
				exp_kind = ACC_PORT_7FFD_WR;
				if (!locked)
					ref_7ffd = dat;
			end else if (ref_model == MODEL_PLUS3 && adr[15:12] == 4'h1 && !adr[1]) begin
				exp_kind = ACC_PORT_1FFD_WR;
				if (!locked)
					ref_1ffd = dat;
			end else if (!adr[0]) begin
				exp_kind   = ACC_ULA_WR;
				ref_border = dat[2:0];
				ref_mic    = dat[3];
				ref_ear    = dat[4];
			end else
				exp_kind = ACC_IO_OTHER_WR;
		end else if (!adr[0]) begin
			exp_kind = ACC_ULA_RD;
			exp_dat  = {1'b1, ~tape, 1'b1, keys};
		end else
			exp_kind = ACC_IO_OTHER_RD;
	endfunction

	// ========================================
	// Compare tasks
	// ========================================

	task automatic stop_run(input string why);
		err_count++;
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string field, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[ERROR] %s: %s expected %0h, actual %0h", test_name, field, exp, act);
		stop_run("Response mismatch");
	endtask

	task automatic check_mem(input logic rom, input logic [PAGE_W-1:0] page,
		input logic [SLOT_OFS_W-1:0] ofs, input logic we);
		if (mem_rom !== rom)
			report_mismatch("mem_rom", 32'(rom), 32'(mem_rom));
		if (mem_page !== page)
			report_mismatch("mem_page", 32'(page), 32'(mem_page));
		if (mem_ofs !== ofs)
			report_mismatch("mem_ofs", 32'(ofs), 32'(mem_ofs));
		if (mem_we !== we)
			report_mismatch("mem_we", 32'(we), 32'(mem_we));
	endtask

	task automatic check_port(input logic [DATA_W-1:0] dat);
		if (wb_dat_r !== dat)
			report_mismatch("wb_dat_r", 32'(dat), 32'(wb_dat_r));
	endtask

	task automatic check_ula(input logic [2:0] border, input logic ear, input logic mic);
		if (border_color !== border)
			report_mismatch("border_color", 32'(border), 32'(border_color));
		if (ear_out !== ear)
			report_mismatch("ear_out", 32'(ear), 32'(ear_out));
		if (mic_out !== mic)
			report_mismatch("mic_out", 32'(mic), 32'(mic_out));
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (!reset && wb_ack === 1'b1) begin
			case (exp_kind)
				ACC_MEM_RD, ACC_MEM_WR:      check_mem(exp_rom, exp_page, exp_ofs, exp_we);
				ACC_ULA_RD, ACC_IO_OTHER_RD: check_port(exp_dat);
				default:                     check_ula(ref_border, ref_ear, ref_mic);
			endcase
		end
	end

	// ========================================
	// Bus driver
	// ========================================

	task automatic apply_reset(input zx_model_t m);
		@(posedge clk_sys);
		reset  <= 1'b1;
		model  <= m;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		repeat (4) @(posedge clk_sys);
		reset      <= 1'b0;
		ref_model  = m;
		ref_7ffd   = '0;
		ref_1ffd   = '0;
		ref_border = 3'd0;
		ref_ear    = 1'b0;
		ref_mic    = 1'b0;
	endtask

	task automatic bus_access(input logic we, input logic io,
		input logic [CPU_ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
		int waited;
		int r;
		r = $random(seed);
		@(posedge clk_sys);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_io    <= io;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		key_data <= r[4:0];
		tape_in  <= r[5];
		zx_ref_access(we, io, adr, dat, r[4:0], r[5]);
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (wb_ack !== 1'b1 && waited < 16);
		if (wb_ack !== 1'b1)
			stop_run("Timeout: no acknowledge from the DUT");
		else if (waited != 3)
			stop_run("Acknowledge did not come 2 cycles after the request");
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic read_all_slots();
		for (int s = 0; s < 4; s++)
			bus_access(1'b0, 1'b0, {s[1:0], 14'h1A5C}, 8'h00);
	endtask

	task automatic random_traffic(input zx_model_t m);
		apply_reset(m);
		repeat (80) begin
			rnd = $random(seed);
			bus_access(rnd[24], rnd[25], rnd[15:0], rnd[23:16]);
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_io     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		model     = MODEL_128K;
		key_data  = '0;
		tape_in   = 1'b0;
		err_count = 0;

		test_name = "reset_map_128k";
		apply_reset(MODEL_128K);
		read_all_slots();
		bus_access(1'b1, 1'b0, 16'h0123, 8'h5A);

		test_name = "port_7ffd";
		repeat (8) begin
			rnd = $random(seed);
			bus_access(1'b1, 1'b1, 16'h7FFD, rnd[7:0] & 8'hDF);
			bus_access(1'b0, 1'b0, {2'b11, rnd[21:8]}, 8'h00);
			bus_access(1'b0, 1'b0, {2'b00, rnd[21:8]}, 8'h00);
		end
		bus_access(1'b1, 1'b1, 16'h7FFD, 8'h23);
		repeat (4) begin
			rnd = $random(seed);
			bus_access(1'b1, 1'b1, 16'h7FFD, rnd[7:0]);
			read_all_slots();
		end

		test_name = "port_1ffd_plus3";
		apply_reset(MODEL_PLUS3);
		for (int cfg = 0; cfg < 4; cfg++) begin
			bus_access(1'b1, 1'b1, 16'h1FFD, {5'd0, cfg[1:0], 1'b1});
			read_all_slots();
		end
		bus_access(1'b1, 1'b1, 16'h1FFD, 8'h04);
		bus_access(1'b1, 1'b1, 16'h7FFD, 8'h16);
		read_all_slots();

		test_name = "ports_ignored_48k";
		apply_reset(MODEL_48K);
		bus_access(1'b1, 1'b1, 16'h7FFD, 8'h17);
		bus_access(1'b1, 1'b1, 16'h1FFD, 8'h05);
		read_all_slots();

		test_name = "ula_port";
		repeat (6) begin
			rnd = $random(seed);
			bus_access(1'b1, 1'b1, 16'h00FE, rnd[7:0]);
			bus_access(1'b0, 1'b1, 16'hFEFE, 8'h00);
			bus_access(1'b0, 1'b1, {rnd[15:1], 1'b1}, 8'h00);
		end

		test_name = "random_48k";
		random_traffic(MODEL_48K);
		test_name = "random_128k";
		random_traffic(MODEL_128K);
		test_name = "random_plus3";
		random_traffic(MODEL_PLUS3);

		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
src/zx_bus_pkg.sv
src/zx_bus_decode.sv
src/zx_paging_exec.sv
src/zx_bus_result.sv
src/zx_bus_top.sv
verif/zx_bus_chk.sv
verif/zx_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, then scan the log for the failure line
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module zx_bus_tb -f flist.f -o zx_bus_sim \
	> build.log 2>&1 || { cat build.log; echo "FAIL: build did not complete"; exit 1; }
./obj_dir/zx_bus_sim > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: simulation did not finish"; exit 1; }
echo "PASS"
